// ==== src/gtiaPkg.sv ====
// ********************
// Shared GTIA constants: register map, AN and mode codes,
// pixel kinds and the hue base color table
// ********************
package gtiaPkg;

  // Color and priority registers, write side
  localparam logic [4:0] colpf0Addr = 5'h16;
  localparam logic [4:0] colpf1Addr = 5'h17;
  localparam logic [4:0] colpf2Addr = 5'h18;
  localparam logic [4:0] colpf3Addr = 5'h19;
  localparam logic [4:0] colbkAddr  = 5'h1A;
  localparam logic [4:0] priorAddr  = 5'h1B;

  // Trigger inputs, read side
  localparam logic [4:0] trig0Addr  = 5'h10;
  localparam logic [4:0] trig1Addr  = 5'h11;
  localparam logic [4:0] trig2Addr  = 5'h12;
  localparam logic [4:0] trig3Addr  = 5'h13;

  // Console switches on read, speaker on write
  localparam logic [4:0] consolAddr = 5'h1F;

  // AN codes in normal priority mode
  localparam logic [2:0] anBackground = 3'd0;
  localparam logic [2:0] anVSync      = 3'd1;
  localparam logic [2:0] anHBlankC40  = 3'd2;
  localparam logic [2:0] anHBlankS40  = 3'd3;
  localparam logic [2:0] anPlayfield0 = 3'd4;
  localparam logic [2:0] anPlayfield1 = 3'd5;
  localparam logic [2:0] anPlayfield2 = 3'd6;
  localparam logic [2:0] anPlayfield3 = 3'd7;

  // PRIOR[7:6]; anything but normal is a special mode
  localparam logic [1:0] modeNormal = 2'd0;

  typedef enum logic [1:0] {
    kindNone   = 2'd0,
    kindPixel  = 2'd1,
    kindHBlank = 2'd2,
    kindVSync  = 2'd3
  } pixelKind;

  // Full-luminance RGB per hue, hue 0 is the gray ramp
  localparam logic [23:0] hueBase [16] = '{
    24'hFFFFFF, 24'hF0D040, 24'hF0A040, 24'hF08060,
    24'hF07080, 24'hE060C0, 24'hB060F0, 24'h8070F0,
    24'h6080F0, 24'h50A0F0, 24'h40C0E0, 24'h40E0C0,
    24'h50F080, 24'h80F050, 24'hC0E040, 24'hF0C040
  };

endpackage

// ==== src/gtiaRegisters.sv ====
// ********************
// Wishbone classic slave with color, background and PRIOR
// registers, plus trigger and console reads
// ********************
module gtiaRegisters (
  input  logic       Fphi0,
  input  logic       rst,
  input  logic       wbCyc,
  input  logic       wbStb,
  input  logic       wbWe,
  input  logic [4:0] wbAdr,
  input  logic [7:0] wbDatW,
  output logic [7:0] wbDatR,
  output logic       wbAck,
  input  logic [3:0] trigger,
  input  logic [3:0] consol,
  output logic [7:0] colpf0,
  output logic [7:0] colpf1,
  output logic [7:0] colpf2,
  output logic [7:0] colpf3,
  output logic [7:0] colbk,
  output logic [7:0] prior
);

  logic       access;
  logic [7:0] readData;

  // New cycle seen, ack not yet given
  assign access = wbCyc && wbStb && !wbAck;

  // Read mux; unmapped addresses return zero
  always_comb begin
    readData = 8'h00;
    case (wbAdr)
      gtiaPkg::trig0Addr:  readData = {7'd0, trigger[0]};
      gtiaPkg::trig1Addr:  readData = {7'd0, trigger[1]};
      gtiaPkg::trig2Addr:  readData = {7'd0, trigger[2]};
      gtiaPkg::trig3Addr:  readData = {7'd0, trigger[3]};
      gtiaPkg::consolAddr: readData = {4'd0, consol};
      gtiaPkg::colpf0Addr: readData = colpf0;
      gtiaPkg::colpf1Addr: readData = colpf1;
      gtiaPkg::colpf2Addr: readData = colpf2;
      gtiaPkg::colpf3Addr: readData = colpf3;
      gtiaPkg::colbkAddr:  readData = colbk;
      gtiaPkg::priorAddr:  readData = prior;
      default:             readData = 8'h00;
    endcase
  end

  // Single-cycle ack, read data captured with it
  always_ff @(posedge Fphi0 or negedge rst) begin
    if (!rst) begin
      wbAck  <= 1'b0;
      wbDatR <= 8'h00;
    end else begin
      wbAck <= access;
      if (access && !wbWe) begin
        wbDatR <= readData;
      end
    end
  end

  // Register writes land on the ack edge
  always_ff @(posedge Fphi0 or negedge rst) begin
    if (!rst) begin
      colpf0 <= 8'h00;
      colpf1 <= 8'h00;
      colpf2 <= 8'h00;
      colpf3 <= 8'h00;
      colbk  <= 8'h00;
      prior  <= 8'h00;
    end else if (access && wbWe) begin
      case (wbAdr)
        gtiaPkg::colpf0Addr: colpf0 <= wbDatW;
        gtiaPkg::colpf1Addr: colpf1 <= wbDatW;
        gtiaPkg::colpf2Addr: colpf2 <= wbDatW;
        gtiaPkg::colpf3Addr: colpf3 <= wbDatW;
        gtiaPkg::colbkAddr:  colbk  <= wbDatW;
        gtiaPkg::priorAddr:  prior  <= wbDatW;
        // Speaker bit and everything else is dropped
        default: ;
      endcase
    end
  end

endmodule

// ==== src/anDecoder.sv ====
// ********************
// AN code decoder, stage 1 of the pixel path
// ********************
module anDecoder (
  input  logic             Fphi0,
  input  logic             rst,
  input  logic [2:0]       an,
  input  logic             anValid,
  input  logic [7:0]       colpf0,
  input  logic [7:0]       colpf1,
  input  logic [7:0]       colpf2,
  input  logic [7:0]       colpf3,
  input  logic [7:0]       colbk,
  input  logic [7:0]       prior,
  output logic [7:0]       colorData,
  output gtiaPkg::pixelKind kind
);

  logic [1:0] mode;
  logic       accept;

  assign mode = prior[7:6];

  // Special GTIA modes are not rendered
  assign accept = anValid && (mode == gtiaPkg::modeNormal);

  always_ff @(posedge Fphi0 or negedge rst) begin
    if (!rst) begin
      kind      <= gtiaPkg::kindNone;
      colorData <= 8'h00;
    end else if (!accept) begin
      kind <= gtiaPkg::kindNone;
    end else begin
      case (an)
        gtiaPkg::anBackground: begin
          colorData <= colbk;
          kind      <= gtiaPkg::kindPixel;
        end
        gtiaPkg::anPlayfield0: begin
          colorData <= colpf0;
          kind      <= gtiaPkg::kindPixel;
        end
        gtiaPkg::anPlayfield1: begin
          colorData <= colpf1;
          kind      <= gtiaPkg::kindPixel;
        end
        gtiaPkg::anPlayfield2: begin
          colorData <= colpf2;
          kind      <= gtiaPkg::kindPixel;
        end
        gtiaPkg::anPlayfield3: begin
          colorData <= colpf3;
          kind      <= gtiaPkg::kindPixel;
        end
        // Blank codes leave colorData alone
        gtiaPkg::anHBlankC40,
        gtiaPkg::anHBlankS40: begin
          kind <= gtiaPkg::kindHBlank;
        end
        gtiaPkg::anVSync: begin
          kind <= gtiaPkg::kindVSync;
        end
        default: begin
          kind <= gtiaPkg::kindNone;
        end
      endcase
    end
  end

endmodule

// ==== src/colorTable.sv ====
// ********************
// Hue/luminance to RGB conversion, stage 2
// ********************
module colorTable (
  input  logic        Fphi0,
  input  logic        rst,
  input  logic [7:0]  colorData,
  output logic [23:0] rgb
);

  logic [3:0]  hue;
  logic [2:0]  lum;
  logic [23:0] baseRgb;
  logic [23:0] scaledRgb;

  // One channel: base * (lum + 1) / 8, truncated
  function automatic logic [7:0] scaleChannel(
    input logic [7:0] base,
    input logic [2:0] level
  );
    logic [11:0] product;
    begin
      product = {4'd0, base} * ({9'd0, level} + 12'd1);
      // At most 255 * 8, so bits 10:3 hold the result
      scaleChannel = product[10:3];
    end
  endfunction

  // Bit 0 of the color byte has no effect
  assign hue = colorData[7:4];
  assign lum = colorData[3:1];

  assign baseRgb = gtiaPkg::hueBase[hue];

  always_comb begin
    scaledRgb[23:16] = scaleChannel(baseRgb[23:16], lum);
    scaledRgb[15:8]  = scaleChannel(baseRgb[15:8], lum);
    scaledRgb[7:0]   = scaleChannel(baseRgb[7:0], lum);
  end

  always_ff @(posedge Fphi0 or negedge rst) begin
    if (!rst) begin
      rgb <= 24'h000000;
    end else begin
      rgb <= scaledRgb;
    end
  end

endmodule

// ==== src/rasterCounter.sv ====
// ********************
// Raster position and display buffer write stage
// ********************
module rasterCounter #(
  parameter int screenWidth  = 320,
  parameter int screenHeight = 192,
  parameter int addrWidth    = 16
) (
  input  logic                 Fphi0,
  input  logic                 rst,
  input  gtiaPkg::pixelKind    kind,
  input  logic [23:0]          rgb,
  output logic [31:0]          dBufData,
  output logic [addrWidth-1:0] dBufAddr,
  output logic                 dBufWriteEn
);

  localparam int xWidth = $clog2(screenWidth);
  localparam int yWidth = $clog2(screenHeight);

  localparam logic [xWidth-1:0]    lastCol  = xWidth'(screenWidth - 1);
  localparam logic [yWidth-1:0]    lastRow  = yWidth'(screenHeight - 1);
  localparam logic [addrWidth-1:0] rowPitch = addrWidth'(screenWidth);

  gtiaPkg::pixelKind kindQ;
  logic [xWidth-1:0] xPos;
  logic [yWidth-1:0] yPos;
  logic [yWidth-1:0] yNext;

  // Kind delayed to sit alongside the colorTable output
  always_ff @(posedge Fphi0 or negedge rst) begin
    if (!rst) begin
      kindQ <= gtiaPkg::kindNone;
    end else begin
      kindQ <= kind;
    end
  end

  assign yNext = (yPos == lastRow) ? '0 : yPos + 1'b1;

  always_ff @(posedge Fphi0 or negedge rst) begin
    if (!rst) begin
      xPos <= '0;
      yPos <= '0;
    end else begin
      case (kindQ)
        gtiaPkg::kindPixel: begin
          if (xPos == lastCol) begin
            xPos <= '0;
            yPos <= yNext;
          end else begin
            xPos <= xPos + 1'b1;
          end
        end
        // No new row when already at the left edge
        gtiaPkg::kindHBlank: begin
          if (xPos != '0) begin
            xPos <= '0;
            yPos <= yNext;
          end
        end
        gtiaPkg::kindVSync: begin
          xPos <= '0;
          yPos <= '0;
        end
        default: ;
      endcase
    end
  end

  assign dBufWriteEn = (kindQ == gtiaPkg::kindPixel);
  assign dBufData    = {8'h00, rgb};
  assign dBufAddr    = addrWidth'(yPos) * rowPitch + addrWidth'(xPos);

endmodule

// ==== src/gtiaTop.sv ====
// ********************
// GTIA color path top level
// ********************
module gtiaTop #(
  parameter int screenWidth  = 320,
  parameter int screenHeight = 192,
  parameter int addrWidth    = 16
) (
  input  logic                 Fphi0,
  input  logic                 rst,
  input  logic                 wbCyc,
  input  logic                 wbStb,
  input  logic                 wbWe,
  input  logic [4:0]           wbAdr,
  input  logic [7:0]           wbDatW,
  output logic [7:0]           wbDatR,
  output logic                 wbAck,
  input  logic [2:0]           an,
  input  logic                 anValid,
  input  logic [3:0]           trigger,
  input  logic [3:0]           consol,
  output logic [31:0]          dBufData,
  output logic [addrWidth-1:0] dBufAddr,
  output logic                 dBufWriteEn
);

  logic [7:0]        colpf0;
  logic [7:0]        colpf1;
  logic [7:0]        colpf2;
  logic [7:0]        colpf3;
  logic [7:0]        colbk;
  logic [7:0]        prior;
  logic [7:0]        colorData;
  logic [23:0]       rgb;
  gtiaPkg::pixelKind kind;

  // Processor side
  gtiaRegisters regFile (
    .Fphi0(Fphi0), .rst(rst),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
    .trigger(trigger), .consol(consol),
    .colpf0(colpf0), .colpf1(colpf1), .colpf2(colpf2), .colpf3(colpf3),
    .colbk(colbk), .prior(prior)
  );

  // Stage 1
  anDecoder decoder (
    .Fphi0(Fphi0), .rst(rst),
    .an(an), .anValid(anValid),
    .colpf0(colpf0), .colpf1(colpf1), .colpf2(colpf2), .colpf3(colpf3),
    .colbk(colbk), .prior(prior),
    .colorData(colorData), .kind(kind)
  );

  // Stage 2
  colorTable colorConv (
    .Fphi0(Fphi0), .rst(rst),
    .colorData(colorData), .rgb(rgb)
  );

  rasterCounter #(
    .screenWidth(screenWidth),
    .screenHeight(screenHeight),
    .addrWidth(addrWidth)
  ) raster (
    .Fphi0(Fphi0), .rst(rst),
    .kind(kind), .rgb(rgb),
    .dBufData(dBufData), .dBufAddr(dBufAddr), .dBufWriteEn(dBufWriteEn)
  );

endmodule

// ==== tests/gtiaTb.sv ====
// ********************
// Directed testbench for the GTIA color path
// ********************
module gtiaTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int screenWidth  = 8;
  localparam int screenHeight = 4;
  localparam int addrWidth    = 16;
  // All tests together run about 150 cycles
  localparam int timeoutCycles = 2000;

  localparam logic [4:0] colorRegs [6] = '{
    gtiaPkg::colpf0Addr, gtiaPkg::colpf1Addr, gtiaPkg::colpf2Addr,
    gtiaPkg::colpf3Addr, gtiaPkg::colbkAddr, gtiaPkg::priorAddr
  };

  logic                 Fphi0;
  logic                 rst;
  logic                 wbCyc;
  logic                 wbStb;
  logic                 wbWe;
  logic [4:0]           wbAdr;
  logic [7:0]           wbDatW;
  logic [7:0]           wbDatR;
  logic                 wbAck;
  logic [2:0]           an;
  logic                 anValid;
  logic [3:0]           trigger;
  logic [3:0]           consol;
  logic [31:0]          dBufData;
  logic [addrWidth-1:0] dBufAddr;
  logic                 dBufWriteEn;

  int          cycleCount;
  int          errors;
  logic [31:0] lcgState;

  // Reference copy of the registers and raster position
  logic [7:0] colbkRef;
  logic [7:0] colpfRef [4];
  logic [7:0] priorRef;
  int         rasterX;
  int         rasterY;

  logic [addrWidth-1:0] expAddr [$];
  logic [31:0]          expData [$];
  int                   expCycle [$];
  logic [addrWidth-1:0] gotAddr [$];
  logic [31:0]          gotData [$];
  int                   gotCycle [$];

  gtiaTop #(
    .screenWidth(screenWidth),
    .screenHeight(screenHeight),
    .addrWidth(addrWidth)
  ) u_dut (
    .Fphi0(Fphi0), .rst(rst),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
    .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
    .an(an), .anValid(anValid), .trigger(trigger), .consol(consol),
    .dBufData(dBufData), .dBufAddr(dBufAddr), .dBufWriteEn(dBufWriteEn)
  );

  initial begin
    Fphi0 = 1'b0;
    cycleCount = 0;
    forever #5 Fphi0 = ~Fphi0;
  end

  always @(posedge Fphi0) begin
    cycleCount <= cycleCount + 1;
  end

  // Buffer writes are taken at the next rising edge
  always @(negedge Fphi0) begin
    if (dBufWriteEn === 1'b1) begin
      gotAddr.push_back(dBufAddr);
      gotData.push_back(dBufData);
      gotCycle.push_back(cycleCount + 1);
    end
  end

  initial begin
    while (cycleCount < timeoutCycles) begin
      @(posedge Fphi0);
    end
    $display("Timeout, the run passed %0d cycles without finishing", timeoutCycles);
    $display("TB FAILED");
    $finish;
  end

  function automatic logic [7:0] nextRand();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState[23:16];
  endfunction

  // Each channel scaled by (lum + 1) / 8 from the hue base
  function automatic logic [31:0] expectedPixel(input logic [7:0] color);
    logic [23:0] base;
    int          lumPlus;
    int          ch;
    logic [31:0] result;
    base = gtiaPkg::hueBase[color[7:4]];
    lumPlus = int'(color[3:1]) + 1;
    result = 32'h0;
    for (ch = 0; ch < 3; ch++) begin
      result[ch*8 +: 8] = 8'((int'(base[ch*8 +: 8]) * lumPlus) / 8);
    end
    return result;
  endfunction

  task automatic modelAn(input logic [2:0] code, input int sampleCycle);
    logic [7:0] color;
    if (priorRef[7:6] == gtiaPkg::modeNormal) begin
      case (code)
        gtiaPkg::anVSync: begin
          rasterX = 0;
          rasterY = 0;
        end
        gtiaPkg::anHBlankC40,
        gtiaPkg::anHBlankS40: begin
          if (rasterX != 0) begin
            rasterX = 0;
            rasterY = (rasterY + 1) % screenHeight;
          end
        end
        default: begin
          color = (code == gtiaPkg::anBackground) ? colbkRef : colpfRef[code[1:0]];
          expAddr.push_back(addrWidth'(rasterY * screenWidth + rasterX));
          expData.push_back(expectedPixel(color));
          expCycle.push_back(sampleCycle + 2);
          rasterX = rasterX + 1;
          if (rasterX == screenWidth) begin
            rasterX = 0;
            rasterY = (rasterY + 1) % screenHeight;
          end
        end
      endcase
    end
  endtask

  // One AN slot, sampled at the next edge
  task automatic sendAn(input logic [2:0] code);
    an = code;
    anValid = 1'b1;
    modelAn(code, cycleCount + 1);
    @(posedge Fphi0);
    #1;
    anValid = 1'b0;
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(posedge Fphi0);
      #1;
    end
  endtask

  task automatic wbAccess(input logic we, input logic [4:0] adr, input logic [7:0] wdat,
                          output logic [7:0] rdat);
    int waited;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = we;
    wbAdr = adr;
    wbDatW = wdat;
    rdat = 8'h00;
    @(posedge Fphi0);
    #1;
    waited = 1;
    while (wbAck !== 1'b1 && waited < 8) begin
      @(posedge Fphi0);
      #1;
      waited++;
    end
    if (wbAck !== 1'b1) begin
      errors++;
      $display("No Wishbone ack within 8 cycles at address 0x%h", adr);
    end else begin
      rdat = wbDatR;
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    @(posedge Fphi0);
    #1;
    if (wbAck !== 1'b0) begin
      errors++;
      $display("Wishbone ack stayed high longer than one cycle at address 0x%h", adr);
    end
  endtask

  task automatic wbWrite(input logic [4:0] adr, input logic [7:0] data);
    logic [7:0] unused;
    wbAccess(1'b1, adr, data, unused);
    case (adr)
      gtiaPkg::colpf0Addr: colpfRef[0] = data;
      gtiaPkg::colpf1Addr: colpfRef[1] = data;
      gtiaPkg::colpf2Addr: colpfRef[2] = data;
      gtiaPkg::colpf3Addr: colpfRef[3] = data;
      gtiaPkg::colbkAddr:  colbkRef = data;
      gtiaPkg::priorAddr:  priorRef = data;
      default: ;
    endcase
  endtask

  task automatic checkRead(input string name, input logic [4:0] adr, input logic [7:0] expected);
    logic [7:0] got;
    wbAccess(1'b0, adr, 8'h00, got);
    if (got !== expected) begin
      errors++;
      $display("MISMATCH %s read 0x%h expected 0x%h actual 0x%h", name, adr, expected, got);
    end
  endtask

  // Drain the two pipeline stages, then compare every buffer write
  task automatic checkWrites(input string name);
    int i;
    idleCycles(4);
    if (gotAddr.size() != expAddr.size()) begin
      errors++;
      $display("MISMATCH %s write count expected %0d actual %0d",
               name, expAddr.size(), gotAddr.size());
    end
    for (i = 0; i < expAddr.size() && i < gotAddr.size(); i++) begin
      if (gotAddr[i] !== expAddr[i]) begin
        errors++;
        $display("MISMATCH %s write %0d address expected %0d actual %0d",
                 name, i, expAddr[i], gotAddr[i]);
      end
      if (gotData[i] !== expData[i]) begin
        errors++;
        $display("MISMATCH %s write %0d data expected 0x%h actual 0x%h",
                 name, i, expData[i], gotData[i]);
      end
      if (gotCycle[i] != expCycle[i]) begin
        errors++;
        $display("MISMATCH %s write %0d cycle expected %0d actual %0d",
                 name, i, expCycle[i], gotCycle[i]);
      end
    end
    expAddr.delete();
    expData.delete();
    expCycle.delete();
    gotAddr.delete();
    gotData.delete();
    gotCycle.delete();
  endtask

  task automatic testRegisters();
    logic [7:0] written [6];
    int         i;
    int         k;
    for (i = 0; i < 6; i++) begin
      written[i] = nextRand();
      wbWrite(colorRegs[i], written[i]);
    end
    for (i = 0; i < 6; i++) begin
      checkRead("registers", colorRegs[i], written[i]);
    end
    wbWrite(gtiaPkg::priorAddr, 8'h00);
    trigger = 4'b1010;
    consol = 4'b0110;
    for (k = 0; k < 4; k++) begin
      checkRead("triggers", 5'(gtiaPkg::trig0Addr + k), {7'd0, trigger[k]});
    end
    checkRead("console", gtiaPkg::consolAddr, {4'd0, consol});
    trigger = 4'b0101;
    consol = 4'b1001;
    for (k = 0; k < 4; k++) begin
      checkRead("triggers", 5'(gtiaPkg::trig0Addr + k), {7'd0, trigger[k]});
    end
    checkRead("console", gtiaPkg::consolAddr, {4'd0, consol});
    checkRead("unmapped", 5'h05, 8'h00);
  endtask

  task automatic testPixelColors();
    sendAn(gtiaPkg::anBackground);
    idleCycles(1);
    sendAn(gtiaPkg::anPlayfield0);
    idleCycles(1);
    sendAn(gtiaPkg::anPlayfield1);
    idleCycles(1);
    sendAn(gtiaPkg::anPlayfield2);
    idleCycles(1);
    sendAn(gtiaPkg::anPlayfield3);
    checkWrites("pixelColors");
  endtask

  task automatic testRaster();
    repeat (screenWidth * screenHeight + 3) sendAn(gtiaPkg::anBackground);
    checkWrites("raster");
  endtask

  task automatic testBlanks();
    sendAn(gtiaPkg::anVSync);
    sendAn(gtiaPkg::anBackground);
    sendAn(gtiaPkg::anBackground);
    // Mid-row blank, next pixel starts row 1
    sendAn(gtiaPkg::anHBlankC40);
    sendAn(gtiaPkg::anBackground);
    sendAn(gtiaPkg::anHBlankS40);
    // Already at x = 0 here
    sendAn(gtiaPkg::anHBlankC40);
    sendAn(gtiaPkg::anPlayfield2);
    sendAn(gtiaPkg::anVSync);
    sendAn(gtiaPkg::anBackground);
    checkWrites("blanks");
  endtask

  task automatic testSpecialModes();
    wbWrite(gtiaPkg::priorAddr, 8'h40);
    sendAn(gtiaPkg::anBackground);
    sendAn(gtiaPkg::anPlayfield1);
    sendAn(gtiaPkg::anHBlankC40);
    wbWrite(gtiaPkg::priorAddr, 8'hC1);
    sendAn(gtiaPkg::anVSync);
    sendAn(gtiaPkg::anPlayfield3);
    wbWrite(gtiaPkg::priorAddr, 8'h00);
    sendAn(gtiaPkg::anBackground);
    sendAn(gtiaPkg::anPlayfield0);
    checkWrites("specialModes");
  endtask

  task automatic testColorUpdate();
    logic [7:0] newColor;
    sendAn(gtiaPkg::anBackground);
    newColor = nextRand();
    if (newColor[7:1] == colbkRef[7:1]) begin
      newColor = ~newColor;
    end
    wbWrite(gtiaPkg::colbkAddr, newColor);
    sendAn(gtiaPkg::anBackground);
    sendAn(gtiaPkg::anBackground);
    checkWrites("colorUpdate");
  endtask

  initial begin
    rst = 1'b0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = 5'd0;
    wbDatW = 8'h00;
    an = 3'd0;
    anValid = 1'b0;
    trigger = 4'd0;
    consol = 4'd0;
    errors = 0;
    lcgState = 32'd17;
    colbkRef = 8'h00;
    priorRef = 8'h00;
    for (int r = 0; r < 4; r++) begin
      colpfRef[r] = 8'h00;
    end
    rasterX = 0;
    rasterY = 0;

    repeat (10) @(posedge Fphi0);
    #1;
    rst = 1'b1;
    idleCycles(2);

    testRegisters();
    testPixelColors();
    testRaster();
    testBlanks();
    testSpecialModes();
    testColorUpdate();

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
src/gtiaPkg.sv
src/gtiaRegisters.sv
src/anDecoder.sv
src/colorTable.sv
src/rasterCounter.sv
src/gtiaTop.sv
tests/gtiaTb.sv

// ==== Makefile ====
# Verilator build and run of the GTIA color path testbench

SRCS := $(shell grep -v '^+' files.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/VgtiaTb: files.f $(SRCS)
	verilator --binary --timing -j 0 --top-module gtiaTb -f files.f -o VgtiaTb

run: obj_dir/VgtiaTb
	./obj_dir/VgtiaTb > sim.log 2>&1
	cat sim.log
	@! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
